// ==== logic/rad_ctrl_settings.svh ====
`ifndef RAD_CTRL_SETTINGS_SVH
`define RAD_CTRL_SETTINGS_SVH

// Bus widths
`define RAD_DATA_W 32
`define RAD_ADDR_W 16
`define RAD_SEL_W 4

// Register index comes from address bits 5..2
`define RAD_IDX_W 4

// Register map, word indices
`define RAD_IDX_DEVICE 0
`define RAD_IDX_VERSION 1
`define RAD_IDX_PPS 4
`define RAD_IDX_RESET 5
`define RAD_IDX_LED 6
`define RAD_IDX_JTAG_L 7
`define RAD_IDX_JTAG_R 8

// Identification words, "RDNT" in ASCII
`define RAD_DEVICE_ID 32'h52444E54
`define RAD_FW_VERSION 32'h00000100

// JTAG shifter, bits per byte and steps within one bit period
`define RAD_JTAG_BITS 8
`define RAD_STEP_DRIVE 1
`define RAD_STEP_TCK_HI 2
`define RAD_STEP_CAPTURE 3
`define RAD_STEP_LAST 4

`endif

// ==== logic/rad_ctrl_pkg.sv ====
`include "rad_ctrl_settings.svh"

package rad_ctrl_pkg;

        // One bus word
        typedef logic [`RAD_DATA_W-1:0] word_t;

        // Byte address on the bus
        typedef logic [`RAD_ADDR_W-1:0] addr_t;

        // Byte selects, one per data byte
        typedef logic [`RAD_SEL_W-1:0] bsel_t;

        // Word index into the register map
        typedef logic [`RAD_IDX_W-1:0] reg_idx_t;

        // TDI, TMS or TDO byte of one shifter
        typedef logic [`RAD_JTAG_BITS-1:0] jtag_byte_t;

        // Bit position in a byte, also the bit count minus one
        typedef logic [$clog2(`RAD_JTAG_BITS)-1:0] bit_cnt_t;

        // Step within one TCK period
        typedef logic [2:0] step_t;

        // Shifter sequence control
        typedef enum logic {
                SHIFT_IDLE,
                SHIFT_RUN
        } shift_state_t;

endpackage

// ==== logic/reg_bus_if.sv ====
`timescale 1ns/1ps

// Decoded register access, from the bus port to the register blocks
interface reg_bus_if;
        // One pulse per write, in the ack cycle
        logic wr_stb;
        rad_ctrl_pkg::reg_idx_t idx;
        rad_ctrl_pkg::word_t wdata;
        rad_ctrl_pkg::bsel_t bsel;

        modport port (output wr_stb, output idx, output wdata, output bsel);
        modport target (input wr_stb, input idx, input wdata, input bsel);
endinterface

// Per side link between a shifter and its pin drive
interface jtag_pin_if;
        logic tdi_bit;
        logic tms_bit;
        // Strobes from the shifter
        logic drive_stb;
        logic tck_rise;
        logic tck_fall;
        logic capture_stb;
        // Registered TDO sample back to the shifter
        logic tdo_bit;

        modport engine (output tdi_bit, output tms_bit, output drive_stb, output tck_rise,
                        output tck_fall, output capture_stb, input tdo_bit);
        modport pins (input tdi_bit, input tms_bit, input drive_stb, input tck_rise,
                      input tck_fall, input capture_stb, output tdo_bit);
endinterface

// ==== logic/wb_reg_port.sv ====
`timescale 1ns/1ps
`include "rad_ctrl_settings.svh"

module wb_reg_port (
        input logic clk_i,
        input logic rst_i,
        input logic wb_cyc_i,
        input logic wb_stb_i,
        input logic wb_we_i,
        input rad_ctrl_pkg::addr_t wb_adr_i,
        input rad_ctrl_pkg::word_t wb_dat_i,
        input rad_ctrl_pkg::bsel_t wb_sel_i,
        output logic wb_ack_o,
        output rad_ctrl_pkg::word_t wb_dat_o,
        reg_bus_if.port bus,
        input rad_ctrl_pkg::word_t ctrl_rd_i,
        input rad_ctrl_pkg::word_t jtag_l_rd_i,
        input rad_ctrl_pkg::word_t jtag_r_rd_i
);

        logic ack_q;
        rad_ctrl_pkg::reg_idx_t idx;

        ////////////////////
        // Acknowledge

        // High one cycle after the strobe, then low one cycle
        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        ack_q <= 1'b0;
                end else begin
                        ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
                end
        end

        // Dropped at once if the master abandons the cycle
        assign wb_ack_o = ack_q && wb_cyc_i;

        ////////////////////
        // Decode

        // Word index, byte lanes ignored
        assign idx = wb_adr_i[`RAD_IDX_W+1:2];

        // Each write lands once, in its ack cycle
        assign bus.wr_stb = wb_ack_o && wb_we_i;
        assign bus.idx = idx;
        assign bus.wdata = wb_dat_i;
        assign bus.bsel = wb_sel_i;

        // Read-back by index, holes read as zero
        always_comb begin
                case (idx)
                        `RAD_IDX_DEVICE, `RAD_IDX_VERSION, `RAD_IDX_PPS,
                        `RAD_IDX_RESET, `RAD_IDX_LED: wb_dat_o = ctrl_rd_i;
                        `RAD_IDX_JTAG_L: wb_dat_o = jtag_l_rd_i;
                        `RAD_IDX_JTAG_R: wb_dat_o = jtag_r_rd_i;
                        default: wb_dat_o = '0;
                endcase
        end

        // Back-to-back acks would apply a write twice
        a_ack_single : assert property (@(posedge clk_i) disable iff (rst_i)
                wb_ack_o |=> !wb_ack_o);

endmodule

// ==== logic/id_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "rad_ctrl_settings.svh"

module id_ctrl_regs (
        input logic clk_i,
        input logic rst_i,
        reg_bus_if.target bus,
        input logic internal_led_i,
        output rad_ctrl_pkg::word_t pps_sel_o,
        output logic jtag_en_o,
        output logic led_o,
        output rad_ctrl_pkg::word_t rd_o
);

        rad_ctrl_pkg::word_t pps_q;
        rad_ctrl_pkg::word_t reset_q;
        logic led_ovr_q;
        logic led_val_q;
        logic led_ovr_next;
        logic led_sw_wr;

        // Replace only the selected bytes
        function automatic rad_ctrl_pkg::word_t byte_merge(input rad_ctrl_pkg::word_t old_w,
                                                           input rad_ctrl_pkg::word_t new_w,
                                                           input rad_ctrl_pkg::bsel_t sel);
                rad_ctrl_pkg::word_t res;
                res = old_w;
                for (int b = 0; b < `RAD_SEL_W; b++) begin
                        if (sel[b])
                                res[8*b +: 8] = new_w[8*b +: 8];
                end
                return res;
        endfunction

        // Override as it will be after this write
        assign led_ovr_next = bus.bsel[2] ? bus.wdata[16] : led_ovr_q;
        assign led_sw_wr = bus.wr_stb && (bus.idx == `RAD_IDX_LED) && bus.bsel[0] && led_ovr_next;

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        pps_q <= '0;
                        reset_q <= '0;
                        led_ovr_q <= 1'b0;
                        led_val_q <= 1'b0;
                end else begin
                        if (bus.wr_stb && bus.idx == `RAD_IDX_PPS)
                                pps_q <= byte_merge(pps_q, bus.wdata, bus.bsel);
                        if (bus.wr_stb && bus.idx == `RAD_IDX_RESET)
                                reset_q <= byte_merge(reset_q, bus.wdata, bus.bsel);
                        if (bus.wr_stb && bus.idx == `RAD_IDX_LED && bus.bsel[2])
                                led_ovr_q <= bus.wdata[16];
                        // Software value, otherwise track the internal LED
                        if (led_sw_wr)
                                led_val_q <= bus.wdata[0];
                        else if (!led_ovr_q)
                                led_val_q <= internal_led_i;
                end
        end

        assign pps_sel_o = pps_q;
        // Bit 31 hands the pins over to the JTAG shifters
        assign jtag_en_o = reset_q[31];
        assign led_o = led_val_q;

        always_comb begin
                case (bus.idx)
                        `RAD_IDX_DEVICE: rd_o = `RAD_DEVICE_ID;
                        `RAD_IDX_VERSION: rd_o = `RAD_FW_VERSION;
                        `RAD_IDX_PPS: rd_o = pps_q;
                        `RAD_IDX_RESET: rd_o = reset_q;
                        `RAD_IDX_LED: rd_o = {15'd0, led_ovr_q, 15'd0, led_val_q};
                        default: rd_o = '0;
                endcase
        end

endmodule

// ==== logic/jtag_shift_engine.sv ====
`timescale 1ns/1ps
`include "rad_ctrl_settings.svh"

module jtag_shift_engine #(
        parameter rad_ctrl_pkg::reg_idx_t SIDE_IDX = `RAD_IDX_JTAG_L
) (
        input logic clk_i,
        input logic rst_i,
        reg_bus_if.target bus,
        input logic jtag_en_i,
        jtag_pin_if.engine pins,
        output rad_ctrl_pkg::word_t rd_o
);

        rad_ctrl_pkg::shift_state_t state;
        rad_ctrl_pkg::step_t step;
        rad_ctrl_pkg::bit_cnt_t bit_idx;
        rad_ctrl_pkg::bit_cnt_t cnt_max;
        logic rev_q;
        logic en_seq_q;
        rad_ctrl_pkg::jtag_byte_t tdi_q;
        rad_ctrl_pkg::jtag_byte_t tms_q;
        rad_ctrl_pkg::jtag_byte_t tdo_q;
        logic wr_hit;
        logic load_rev;
        logic start;
        logic running;

        // MSB to LSB swap of a TDI byte
        function automatic rad_ctrl_pkg::jtag_byte_t bit_reverse(input rad_ctrl_pkg::jtag_byte_t d);
                rad_ctrl_pkg::jtag_byte_t r;
                for (int i = 0; i < `RAD_JTAG_BITS; i++) begin
                        r[i] = d[`RAD_JTAG_BITS-1-i];
                end
                return r;
        endfunction

        assign wr_hit = bus.wr_stb && (bus.idx == SIDE_IDX);
        // Reverse flag of this write, else the stored one on a TDI-only write
        assign load_rev = bus.bsel[3] ? bus.wdata[29] : rev_q;
        // Streaming restarts on any write without byte 3 while enable is stored
        assign start = wr_hit && jtag_en_i &&
                       (bus.bsel[3] ? bus.wdata[30] : en_seq_q);
        assign running = (state == rad_ctrl_pkg::SHIFT_RUN);

        ////////////////////
        // Sequence control

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        state <= rad_ctrl_pkg::SHIFT_IDLE;
                        step <= '0;
                        bit_idx <= '0;
                        cnt_max <= '0;
                        rev_q <= 1'b0;
                        en_seq_q <= 1'b0;
                end else begin
                        if (wr_hit && bus.bsel[3]) begin
                                cnt_max <= bus.wdata[26:24];
                                rev_q <= bus.wdata[29];
                                en_seq_q <= bus.wdata[30];
                        end
                        if (!running) begin
                                if (start) begin
                                        state <= rad_ctrl_pkg::SHIFT_RUN;
                                        step <= rad_ctrl_pkg::step_t'(`RAD_STEP_DRIVE);
                                        bit_idx <= '0;
                                end
                        end else if (!jtag_en_i) begin
                                // Pins taken back mid-sequence, abandon it
                                state <= rad_ctrl_pkg::SHIFT_IDLE;
                                step <= '0;
                        end else if (step == rad_ctrl_pkg::step_t'(`RAD_STEP_LAST)) begin
                                if (bit_idx == cnt_max) begin
                                        state <= rad_ctrl_pkg::SHIFT_IDLE;
                                        step <= '0;
                                end else begin
                                        step <= rad_ctrl_pkg::step_t'(`RAD_STEP_DRIVE);
                                        bit_idx <= bit_idx + 1'b1;
                                end
                        end else begin
                                step <= step + 1'b1;
                        end
                end
        end

        ////////////////////
        // Data bytes

        always_ff @(posedge clk_i) begin
                if (wr_hit && bus.bsel[0])
                        tdi_q <= load_rev ? bit_reverse(bus.wdata[7:0]) : bus.wdata[7:0];
                if (wr_hit && bus.bsel[1])
                        tms_q <= bus.wdata[15:8];
                // TDO lands in the slot of the bit just shifted
                if (pins.tck_fall)
                        tdo_q[bit_idx] <= pins.tdo_bit;
        end

        // LSB first
        assign pins.tdi_bit = tdi_q[bit_idx];
        assign pins.tms_bit = tms_q[bit_idx];
        assign pins.drive_stb = running && (step == rad_ctrl_pkg::step_t'(`RAD_STEP_DRIVE));
        assign pins.tck_rise = running && (step == rad_ctrl_pkg::step_t'(`RAD_STEP_TCK_HI));
        assign pins.capture_stb = running && (step == rad_ctrl_pkg::step_t'(`RAD_STEP_CAPTURE));
        assign pins.tck_fall = running && (step == rad_ctrl_pkg::step_t'(`RAD_STEP_LAST));

        assign rd_o = (bus.idx == SIDE_IDX) ?
                      {running, en_seq_q, rev_q, 2'b00, cnt_max, tdo_q, tms_q, tdi_q} : '0;

        // Every TCK rise gets its own fall two clocks later
        a_tck_pair : assert property (@(posedge clk_i) disable iff (rst_i || !jtag_en_i)
                pins.tck_rise |-> !pins.tck_fall ##2 pins.tck_fall);

endmodule

// ==== logic/jtag_pin_drive.sv ====
`timescale 1ns/1ps

module jtag_pin_drive (
        input logic clk_i,
        input logic rst_i,
        jtag_pin_if.pins pins,
        input logic jtag_en_i,
        input logic sclk_i,
        input logic tdo_i,
        output logic tck_o,
        output logic tdi_o,
        output logic tms_o
);

        logic tdo_q;

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        tck_o <= 1'b0;
                        tdi_o <= 1'b0;
                        tms_o <= 1'b0;
                end else if (!jtag_en_i) begin
                        // Pass-through clock, data lines parked low
                        tck_o <= sclk_i;
                        tdi_o <= 1'b0;
                        tms_o <= 1'b0;
                end else begin
                        if (pins.drive_stb) begin
                                tdi_o <= pins.tdi_bit;
                                tms_o <= pins.tms_bit;
                        end
                        if (pins.tck_rise)
                                tck_o <= 1'b1;
                        else if (pins.tck_fall)
                                tck_o <= 1'b0;
                end
        end

        // TDO sampled while TCK is high
        always_ff @(posedge clk_i) begin
                if (rst_i)
                        tdo_q <= 1'b0;
                else if (jtag_en_i && pins.capture_stb)
                        tdo_q <= tdo_i;
        end

        assign pins.tdo_bit = tdo_q;

endmodule

// ==== logic/rad_id_ctrl.sv ====
`timescale 1ns/1ps
`include "rad_ctrl_settings.svh"

module rad_id_ctrl (
        input logic clk_i,
        input logic rst_i,
        input logic wb_cyc_i,
        input logic wb_stb_i,
        input logic wb_we_i,
        input rad_ctrl_pkg::addr_t wb_adr_i,
        input rad_ctrl_pkg::word_t wb_dat_i,
        input rad_ctrl_pkg::bsel_t wb_sel_i,
        output logic wb_ack_o,
        output rad_ctrl_pkg::word_t wb_dat_o,
        input logic internal_led_i,
        // Side 0 is left, side 1 is right
        input logic [1:0] sclk_i,
        input logic [1:0] tdo_i,
        output logic [1:0] tck_o,
        output logic [1:0] tdi_o,
        output logic [1:0] tms_o,
        output logic jtag_en_o,
        output rad_ctrl_pkg::word_t pps_sel_o,
        output logic led_o
);

        rad_ctrl_pkg::word_t ctrl_rd;
        rad_ctrl_pkg::word_t jtag_l_rd;
        rad_ctrl_pkg::word_t jtag_r_rd;

        reg_bus_if u_bus ();
        jtag_pin_if u_pin_l ();
        jtag_pin_if u_pin_r ();

        // Bus side
        wb_reg_port u_port (.clk_i(clk_i), .rst_i(rst_i), .wb_cyc_i(wb_cyc_i),
                .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
                .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_ack_o(wb_ack_o),
                .wb_dat_o(wb_dat_o), .bus(u_bus.port), .ctrl_rd_i(ctrl_rd),
                .jtag_l_rd_i(jtag_l_rd), .jtag_r_rd_i(jtag_r_rd));

        // Registers and shifters
        id_ctrl_regs u_regs (.clk_i(clk_i), .rst_i(rst_i), .bus(u_bus.target),
                .internal_led_i(internal_led_i), .pps_sel_o(pps_sel_o),
                .jtag_en_o(jtag_en_o), .led_o(led_o), .rd_o(ctrl_rd));

        jtag_shift_engine #(.SIDE_IDX(`RAD_IDX_JTAG_L)) u_shift_l (.clk_i(clk_i),
                .rst_i(rst_i), .bus(u_bus.target), .jtag_en_i(jtag_en_o),
                .pins(u_pin_l.engine), .rd_o(jtag_l_rd));

        jtag_shift_engine #(.SIDE_IDX(`RAD_IDX_JTAG_R)) u_shift_r (.clk_i(clk_i),
                .rst_i(rst_i), .bus(u_bus.target), .jtag_en_i(jtag_en_o),
                .pins(u_pin_r.engine), .rd_o(jtag_r_rd));

        // Pin side
        jtag_pin_drive u_drive_l (.clk_i(clk_i), .rst_i(rst_i), .pins(u_pin_l.pins),
                .jtag_en_i(jtag_en_o), .sclk_i(sclk_i[0]), .tdo_i(tdo_i[0]),
                .tck_o(tck_o[0]), .tdi_o(tdi_o[0]), .tms_o(tms_o[0]));

        jtag_pin_drive u_drive_r (.clk_i(clk_i), .rst_i(rst_i), .pins(u_pin_r.pins),
                .jtag_en_i(jtag_en_o), .sclk_i(sclk_i[1]), .tdo_i(tdo_i[1]),
                .tck_o(tck_o[1]), .tdi_o(tdi_o[1]), .tms_o(tms_o[1]));

endmodule

// ==== verification/rad_id_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "rad_ctrl_settings.svh"

module rad_id_ctrl_tb;

        // Bounds for every wait loop, in clocks or polls
        localparam int ACK_LIMIT = 16;
        localparam int POLL_LIMIT = 40;

        // One bus access of the stimulus table
        typedef struct packed {
                logic wr;
                logic [15:0] addr;
                logic [31:0] data;
                logic [3:0] sel;
                logic [31:0] exp;
        } bus_op_t;

        logic clk_i = 1'b0;
        logic rst_i;
        logic wb_cyc_i;
        logic wb_stb_i;
        logic wb_we_i;
        logic [15:0] wb_adr_i;
        logic [31:0] wb_dat_i;
        logic [3:0] wb_sel_i;
        logic wb_ack_o;
        logic [31:0] wb_dat_o;
        logic internal_led_i;
        logic [1:0] sclk_i;
        logic [1:0] tdo_i;
        logic [1:0] tck_o;
        logic [1:0] tdi_o;
        logic [1:0] tms_o;
        logic jtag_en_o;
        logic [31:0] pps_sel_o;
        logic led_o;

        bus_op_t table_q[$];
        string name_q[$];

        // Bits seen at each TCK rise, shifted in from the top
        logic [7:0] cap_tdi [2];
        logic [7:0] cap_tms [2];
        int rise_cnt [2] = '{0, 0};
        logic [1:0] tck_prev = 2'b00;

        rad_id_ctrl u_dut (.clk_i(clk_i), .rst_i(rst_i), .wb_cyc_i(wb_cyc_i),
                .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
                .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_ack_o(wb_ack_o),
                .wb_dat_o(wb_dat_o), .internal_led_i(internal_led_i), .sclk_i(sclk_i),
                .tdo_i(tdo_i), .tck_o(tck_o), .tdi_o(tdi_o), .tms_o(tms_o),
                .jtag_en_o(jtag_en_o), .pps_sel_o(pps_sel_o), .led_o(led_o));

        // 40 ns clock
        always #20 clk_i = ~clk_i;

        // Loopback, each side's TDO is its own TDI
        assign tdo_i = tdi_o;

        ////////////////////
        // TCK monitor

        // Outputs change on the rising edge, sampled here on the falling one
        always @(negedge clk_i) begin
                for (int s = 0; s < 2; s++) begin
                        if (jtag_en_o && tck_o[s] && !tck_prev[s]) begin
                                cap_tdi[s] = {tdi_o[s], cap_tdi[s][7:1]};
                                cap_tms[s] = {tms_o[s], cap_tms[s][7:1]};
                                rise_cnt[s]++;
                        end
                        tck_prev[s] = tck_o[s];
                end
        end

        ////////////////////
        // Helpers

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("FAIL: see errors above");
                $fatal(1, "Simulation halted");
        endtask

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                if (act !== exp)
                        stop_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        endtask

        function automatic logic [15:0] addr_of(input int idx);
                return 16'(idx << 2);
        endfunction

        function automatic int side_idx(input int side);
                return (side == 0) ? `RAD_IDX_JTAG_L : `RAD_IDX_JTAG_R;
        endfunction

        // Shifter word with a full count of 8 bits
        function automatic logic [31:0] shift_word(input logic en, input logic rev,
                                                   input logic [7:0] tms,
                                                   input logic [7:0] tdi);
                return {1'b0, en, rev, 2'b00, 3'd7, 8'h00, tms, tdi};
        endfunction

        // Holds cyc and stb until ack is seen, one more clock for the write to land
        task automatic bus_access(input logic wr, input logic [15:0] addr,
                                  input logic [31:0] data, input logic [3:0] sel,
                                  input string name, output logic [31:0] rd);
                int waited;
                @(negedge clk_i);
                wb_cyc_i = 1'b1;
                wb_stb_i = 1'b1;
                wb_we_i = wr;
                wb_adr_i = addr;
                wb_dat_i = data;
                wb_sel_i = sel;
                waited = 0;
                do begin
                        @(negedge clk_i);
                        waited++;
                        if (waited > ACK_LIMIT)
                                stop_run({"Bus stalled, no ack for access ", name});
                end while (wb_ack_o !== 1'b1);
                rd = wb_dat_o;
                @(negedge clk_i);
                wb_cyc_i = 1'b0;
                wb_stb_i = 1'b0;
                wb_we_i = 1'b0;
        endtask

        task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                                 input logic [3:0] sel, input string name);
                logic [31:0] unused;
                bus_access(1'b1, addr, data, sel, name, unused);
        endtask

        task automatic bus_read(input logic [15:0] addr, input string name,
                                output logic [31:0] rd);
                bus_access(1'b0, addr, 32'h0, 4'hF, name, rd);
        endtask

        function automatic void add_op(input string name, input logic wr,
                                       input logic [15:0] addr, input logic [31:0] data,
                                       input logic [3:0] sel, input logic [31:0] exp);
                bus_op_t op;
                op.wr = wr;
                op.addr = addr;
                op.data = data;
                op.sel = sel;
                op.exp = exp;
                table_q.push_back(op);
                name_q.push_back(name);
        endfunction

        task automatic apply_table();
                logic [31:0] rd;
                foreach (table_q[i]) begin
                        if (table_q[i].wr) begin
                                bus_write(table_q[i].addr, table_q[i].data, table_q[i].sel,
                                          name_q[i]);
                        end else begin
                                bus_read(table_q[i].addr, name_q[i], rd);
                                check_value(name_q[i], table_q[i].exp, rd);
                        end
                end
        endtask

        // Start one sequence, poll the running bit, then check pins and TDO
        task automatic run_sequence(input int side, input string name,
                                    input logic [31:0] data, input logic [3:0] sel,
                                    input logic [7:0] exp_seq, input logic [7:0] exp_tms);
                int start_cnt;
                int polls;
                logic [31:0] rd;
                start_cnt = rise_cnt[side];
                bus_write(addr_of(side_idx(side)), data, sel, name);
                polls = 0;
                bus_read(addr_of(side_idx(side)), name, rd);
                while (rd[31] !== 1'b0) begin
                        polls++;
                        if (polls > POLL_LIMIT)
                                stop_run({"Shifter never cleared its running bit in ", name});
                        bus_read(addr_of(side_idx(side)), name, rd);
                end
                check_value({name, " tck pulses"}, 8, rise_cnt[side] - start_cnt);
                check_value({name, " tdi bits"}, exp_seq, cap_tdi[side]);
                check_value({name, " tms bits"}, exp_tms, cap_tms[side]);
                check_value({name, " tdi field"}, exp_seq, rd[7:0]);
                check_value({name, " tdo field"}, exp_seq, rd[23:16]);
        endtask

        ////////////////////
        // Test sequence

        initial begin
                logic [31:0] pps_a;
                logic [31:0] pps_b;
                logic [31:0] pps_exp;
                logic [31:0] snap_r;
                logic [31:0] rd;
                logic [1:0] sclk_prev;
                logic [7:0] tdi_l;
                logic [7:0] tms_l;
                logic [7:0] tdi_r;
                logic [7:0] tms_r;
                logic [7:0] tdi_x;
                logic [7:0] rev_x;
                int rise_r;

                void'($urandom(20));
                rst_i = 1'b1;
                wb_cyc_i = 1'b0;
                wb_stb_i = 1'b0;
                wb_we_i = 1'b0;
                wb_adr_i = '0;
                wb_dat_i = '0;
                wb_sel_i = '0;
                internal_led_i = 1'b0;
                sclk_i = 2'b00;
                repeat (5) @(negedge clk_i);
                rst_i = 1'b0;

                // ID, version, holes and PPS through the table
                pps_a = $urandom;
                pps_b = $urandom;
                pps_exp = {pps_a[31:16], pps_b[15:8], pps_a[7:0]};
                add_op("device id", 1'b0, addr_of(`RAD_IDX_DEVICE), 0, 4'hF, "RDNT");
                add_op("version", 1'b0, addr_of(`RAD_IDX_VERSION), 0, 4'hF, `RAD_FW_VERSION);
                add_op("hole 2", 1'b0, addr_of(2), 0, 4'hF, 32'h0);
                add_op("hole 15", 1'b0, addr_of(15), 0, 4'hF, 32'h0);
                add_op("pps write", 1'b1, addr_of(`RAD_IDX_PPS), pps_a, 4'hF, 0);
                add_op("pps read", 1'b0, addr_of(`RAD_IDX_PPS), 0, 4'hF, pps_a);
                add_op("pps byte 1", 1'b1, addr_of(`RAD_IDX_PPS), pps_b, 4'b0010, 0);
                add_op("pps merged", 1'b0, addr_of(`RAD_IDX_PPS), 0, 4'hF, pps_exp);
                add_op("reset clear", 1'b0, addr_of(`RAD_IDX_RESET), 0, 4'hF, 32'h0);
                apply_table();
                check_value("pps_sel_o", pps_exp, pps_sel_o);

                // LED tracks the internal source, then the software override
                internal_led_i = 1'b1;
                repeat (2) @(negedge clk_i);
                check_value("led follows high", 1, led_o);
                internal_led_i = 1'b0;
                repeat (2) @(negedge clk_i);
                check_value("led follows low", 0, led_o);
                bus_write(addr_of(`RAD_IDX_LED), 32'h0001_0001, 4'b0101, "led override");
                internal_led_i = 1'b1;
                repeat (2) @(negedge clk_i);
                internal_led_i = 1'b0;
                repeat (2) @(negedge clk_i);
                check_value("led held", 1, led_o);
                bus_read(addr_of(`RAD_IDX_LED), "led read", rd);
                check_value("led read", 32'h0001_0001, rd);
                bus_write(addr_of(`RAD_IDX_LED), 32'h0, 4'b0100, "led release");
                repeat (2) @(negedge clk_i);
                check_value("led released", 0, led_o);

                // Hand the pins to the shifters
                bus_write(addr_of(`RAD_IDX_RESET), 32'h8000_0000, 4'b1000, "jtag enable");
                check_value("jtag_en_o", 1, jtag_en_o);
                check_value("tck idle", 0, tck_o);

                // Right side first, its state must survive left side traffic
                tdi_r = 8'($urandom);
                // Top TMS bit set so the right pin is left high
                tms_r = 8'($urandom) | 8'h80;
                run_sequence(1, "right plain", shift_word(1'b1, 1'b0, tms_r, tdi_r), 4'b1011,
                             tdi_r, tms_r);
                bus_read(addr_of(`RAD_IDX_JTAG_R), "right snapshot", snap_r);
                rise_r = rise_cnt[1];

                tdi_l = 8'($urandom);
                tms_l = 8'($urandom);
                run_sequence(0, "left plain", shift_word(1'b1, 1'b0, tms_l, tdi_l), 4'b1011,
                             tdi_l, tms_l);

                // Reverse flag in the same write
                tdi_x = 8'($urandom);
                rev_x = {<<{tdi_x}};
                run_sequence(0, "left reverse", shift_word(1'b1, 1'b1, tms_l, tdi_x), 4'b1011,
                             rev_x, tms_l);

                // TDI-only write restarts, stored reverse flag still applies
                tdi_x = 8'($urandom);
                rev_x = {<<{tdi_x}};
                run_sequence(0, "left stream reverse", {24'h0, tdi_x}, 4'b0001, rev_x, tms_l);

                check_value("right untouched tck", rise_r, rise_cnt[1]);
                bus_read(addr_of(`RAD_IDX_JTAG_R), "right after left", rd);
                check_value("right untouched reg", snap_r, rd);

                // Streaming on the right side, TMS kept from the first write
                // Last TDI bit high, so the right data pins end high
                tdi_x = 8'($urandom) | 8'h80;
                run_sequence(1, "right stream", {24'h0, tdi_x}, 4'b0001, tdi_x, tms_r);

                // JTAG off again, TCK is sclk one clock late and the data pins park low
                bus_write(addr_of(`RAD_IDX_RESET), 32'h0, 4'b1000, "jtag disable");
                check_value("jtag_en_o off", 0, jtag_en_o);
                sclk_prev = sclk_i;
                repeat (24) begin
                        @(negedge clk_i);
                        check_value("pass tck", sclk_prev, tck_o);
                        check_value("pass tdi low", 0, tdi_o);
                        check_value("pass tms low", 0, tms_o);
                        sclk_i = 2'($urandom);
                        sclk_prev = sclk_i;
                end
                sclk_i = 2'b00;

                $display("PASS: all tests");
                $finish;
        end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/rad_ctrl_pkg.sv
logic/reg_bus_if.sv
logic/wb_reg_port.sv
logic/id_ctrl_regs.sv
logic/jtag_shift_engine.sv
logic/jtag_pin_drive.sv
logic/rad_id_ctrl.sv
verification/rad_id_ctrl_tb.sv
